// File: rtl/img_pkg.sv
`default_nettype none

package img_pkg;

   // Pixel and stream sizes
   localparam int unsigned pixel_width = 10;
   localparam int unsigned data_width  = 16;
   localparam int unsigned max_cols    = 1288;   // Longest supported line
   localparam int unsigned col_width   = 11;

   typedef logic [3:0] dtype_t;

   localparam dtype_t dtype_frame_start = 4'h1;
   localparam dtype_t dtype_frame_end   = 4'h2;
   localparam dtype_t dtype_row_start   = 4'h3;
   localparam dtype_t dtype_row_end     = 4'h4;
   localparam dtype_t dtype_pixel       = 4'h8;
   localparam dtype_t dtype_pixel_mask  = 4'h8;  // Any code with bit 3 set carries a pixel

   // Stream data word, raw pixel on pixel beats, metadata on marker beats
   typedef union packed {
      struct packed {
         logic [data_width-pixel_width-1:0] pad;
         logic [pixel_width-1:0]            pix;
      } px;
      logic [data_width-1:0] meta;
   } stream_word_u;

   // win[row][col], row 0 is the oldest line, col 0 the leftmost column
   typedef logic [2:0][2:0][pixel_width-1:0] window_t;

   // Bit 1 row phase, bit 0 column phase
   // 0 means the first window centre handed to the interpolator is red
   typedef logic [1:0] phase_t;

   // Register port
   localparam int unsigned axi_addr_width = 4;
   localparam int unsigned axi_data_width = 32;

   localparam logic [axi_addr_width-1:0] csr_ctrl_addr   = 4'h0;  // [0] enable, [2:1] phase
   localparam logic [axi_addr_width-1:0] csr_status_addr = 4'h4;  // [15:0] frame count

   localparam logic [1:0] axi_resp_okay   = 2'b00;
   localparam logic [1:0] axi_resp_slverr = 2'b10;

endpackage

`default_nettype wire

// File: rtl/kernel_if.sv
`timescale 1ns/1ps
`default_nettype none

interface kernel_if;

   logic                  dv;      // One tagged event per cycle
   img_pkg::dtype_t       dtype;
   img_pkg::stream_word_u word;    // Marker metadata passes here untouched
   img_pkg::window_t      win;     // Only meaningful on pixel events

   modport src (
      output dv,
      output dtype,
      output word,
      output win
   );

   modport snk (
      input dv,
      input dtype,
      input word,
      input win
   );

endinterface

`default_nettype wire

// File: rtl/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module line_buffer (
   input  logic                            clk,
   input  logic                            resetb,
   input  logic                            wr_en,
   input  logic [img_pkg::col_width-1:0]   col,
   input  logic [img_pkg::pixel_width-1:0] din,
   output logic [img_pkg::pixel_width-1:0] dout
);

   logic [img_pkg::pixel_width-1:0] mem [0:img_pkg::max_cols-1];

   // Read happens every cycle, so a buffer that is not being written
   // still presents the stored row at the current column
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dout <= '0;
      end else begin
         dout <= mem[col];   // Value from before this edge's write
      end
   end

   // Overwrite with the new row
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[col] <= din;
      end
   end

endmodule

`default_nettype wire

// File: rtl/kernel.sv
`timescale 1ns/1ps
`default_nettype none

module kernel (
   input  logic                  clk,
   input  logic                  resetb,
   input  logic                  enable,
   input  logic                  dvi,
   input  img_pkg::dtype_t       dtypei,
   input  img_pkg::stream_word_u datai,
   kernel_if.src                 kif
);

   logic                                 active;    // Frame was enabled at its start
   logic [img_pkg::col_width-1:0]        row_cnt;
   logic [img_pkg::col_width-1:0]        col_cnt;   // Column of the next pixel
   logic                                 is_pixel;
   logic                                 take_pix;
   logic                                 emit;
   logic                                 pix_q;
   logic [img_pkg::pixel_width-1:0]      cur_q;
   logic [img_pkg::pixel_width-1:0]      even_dout;
   logic [img_pkg::pixel_width-1:0]      odd_dout;
   logic [2:0][img_pkg::pixel_width-1:0] tap;       // Current column, top to bottom
   logic [2:0][img_pkg::pixel_width-1:0] col_m1;
   logic [2:0][img_pkg::pixel_width-1:0] col_m2;

   assign is_pixel = |(dtypei & img_pkg::dtype_pixel_mask);
   assign take_pix = dvi && active && is_pixel;

   // Even rows are written to one buffer and odd rows to the other,
   // so together they always hold the two previous lines
   line_buffer lb_even_inst (
      .clk    (clk),
      .resetb (resetb),
      .wr_en  (take_pix && !row_cnt[0]),
      .col    (col_cnt),
      .din    (datai.px.pix),
      .dout   (even_dout)
   );

   line_buffer lb_odd_inst (
      .clk    (clk),
      .resetb (resetb),
      .wr_en  (take_pix && row_cnt[0]),
      .col    (col_cnt),
      .din    (datai.px.pix),
      .dout   (odd_dout)
   );

   // Border rules
   always_comb begin
      emit = 1'b0;
      if (dvi) begin
         case (dtypei)
            img_pkg::dtype_frame_start: emit = enable;
            img_pkg::dtype_frame_end:   emit = active;
            img_pkg::dtype_row_start,
            img_pkg::dtype_row_end:     emit = active && (row_cnt >= 2);
            default:                    emit = take_pix && (row_cnt >= 2) && (col_cnt >= 2);
         endcase
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         active  <= 1'b0;
         row_cnt <= '0;
         col_cnt <= '0;
         pix_q   <= 1'b0;
         kif.dv  <= 1'b0;
      end else begin
         kif.dv <= emit;
         pix_q  <= take_pix;
         if (dvi) begin
            case (dtypei)
               img_pkg::dtype_frame_start: begin
                  active  <= enable;   // Enable only takes effect here
                  row_cnt <= '0;
               end
               img_pkg::dtype_frame_end: active <= 1'b0;
               img_pkg::dtype_row_start: col_cnt <= '0;
               img_pkg::dtype_row_end: begin
                  if (active) begin
                     row_cnt <= row_cnt + 1'b1;
                  end
               end
               default: begin
                  if (take_pix) begin
                     col_cnt <= col_cnt + 1'b1;
                  end
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (dvi) begin
         kif.dtype <= dtypei;
         kif.word  <= datai;
      end
      if (take_pix) begin
         cur_q <= datai.px.pix;
      end
      if (pix_q) begin
         col_m2 <= col_m1;
         col_m1 <= tap;
      end
   end

   // row_cnt still holds the beat's row during the output cycle
   assign tap[0] = row_cnt[0] ? odd_dout : even_dout;
   assign tap[1] = row_cnt[0] ? even_dout : odd_dout;
   assign tap[2] = cur_q;

   always_comb begin
      for (int y = 0; y < 3; y++) begin
         kif.win[y][0] = col_m2[y];
         kif.win[y][1] = col_m1[y];
         kif.win[y][2] = tap[y];
      end
   end

endmodule

`default_nettype wire

// File: rtl/interp_bilinear.sv
`timescale 1ns/1ps
`default_nettype none

module interp_bilinear (
   input  logic                            clk,
   input  logic                            resetb,
   input  img_pkg::phase_t                 phase,
   kernel_if.snk                           kif,
   output logic                            dvo,
   output logic [img_pkg::pixel_width-1:0] r,
   output logic [img_pkg::pixel_width-1:0] g,
   output logic [img_pkg::pixel_width-1:0] b,
   output img_pkg::dtype_t                 dtypeo,
   output img_pkg::stream_word_u           meta_datao,
   output logic                            frame_done
);

   logic                              row_phase;
   logic                              col_phase;
   logic                              is_pixel;
   logic [img_pkg::pixel_width+1:0]   plus_sum;
   logic [img_pkg::pixel_width+1:0]   diamond_sum;
   logic [img_pkg::pixel_width:0]     vert_sum;
   logic [img_pkg::pixel_width:0]     horz_sum;
   logic [img_pkg::pixel_width-1:0]   kcenter;
   logic [img_pkg::pixel_width-1:0]   kplus;
   logic [img_pkg::pixel_width-1:0]   kdiamond;
   logic [img_pkg::pixel_width-1:0]   kvert;
   logic [img_pkg::pixel_width-1:0]   khorz;

   assign is_pixel = |(kif.dtype & img_pkg::dtype_pixel_mask);
   assign kcenter  = kif.win[1][1];

   // Two guard bits on the four-way sums, +2 rounds before the shift
   assign plus_sum    = {2'b00, kif.win[0][1]} + {2'b00, kif.win[2][1]}
                      + {2'b00, kif.win[1][0]} + {2'b00, kif.win[1][2]} + 2'd2;
   assign diamond_sum = {2'b00, kif.win[0][0]} + {2'b00, kif.win[0][2]}
                      + {2'b00, kif.win[2][0]} + {2'b00, kif.win[2][2]} + 2'd2;
   assign vert_sum    = {1'b0, kif.win[0][1]} + {1'b0, kif.win[2][1]} + 1'b1;
   assign horz_sum    = {1'b0, kif.win[1][0]} + {1'b0, kif.win[1][2]} + 1'b1;

   assign kplus    = plus_sum[img_pkg::pixel_width+1:2];
   assign kdiamond = diamond_sum[img_pkg::pixel_width+1:2];
   assign kvert    = vert_sum[img_pkg::pixel_width:1];
   assign khorz    = horz_sum[img_pkg::pixel_width:1];

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dvo        <= 1'b0;
         r          <= '0;
         g          <= '0;
         b          <= '0;
         dtypeo     <= '0;
         meta_datao <= '0;
         frame_done <= 1'b0;
         row_phase  <= 1'b0;
         col_phase  <= 1'b0;
      end else begin
         dvo        <= kif.dv;
         frame_done <= kif.dv && (kif.dtype == img_pkg::dtype_frame_end);
         if (kif.dv) begin
            dtypeo     <= kif.dtype;
            meta_datao <= kif.word;
            if (kif.dtype == img_pkg::dtype_frame_start) begin
               row_phase <= phase[1];
            end else if (kif.dtype == img_pkg::dtype_row_start) begin
               col_phase <= phase[0];   // Reloaded on every line
            end else if (kif.dtype == img_pkg::dtype_row_end) begin
               row_phase <= !row_phase;
            end else if (is_pixel) begin
               col_phase <= !col_phase;
               case ({row_phase, col_phase})
                  2'd0: begin   // Red site
                     r <= kcenter;
                     g <= kplus;
                     b <= kdiamond;
                  end
                  2'd1: begin   // Green on a red row
                     r <= khorz;
                     g <= kcenter;
                     b <= kvert;
                  end
                  2'd2: begin   // Green on a blue row
                     r <= kvert;
                     g <= kcenter;
                     b <= khorz;
                  end
                  default: begin   // Blue site
                     r <= kdiamond;
                     g <= kplus;
                     b <= kcenter;
                  end
               endcase
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/demosaic_csr.sv
`timescale 1ns/1ps
`default_nettype none

module demosaic_csr (
   input  logic                                clk,
   input  logic                                resetb,
   input  logic [img_pkg::axi_addr_width-1:0]  awaddr,
   input  logic                                awvalid,
   output logic                                awready,
   input  logic [img_pkg::axi_data_width-1:0]  wdata,
   input  logic [img_pkg::axi_data_width/8-1:0] wstrb,
   input  logic                                wvalid,
   output logic                                wready,
   output logic [1:0]                          bresp,
   output logic                                bvalid,
   input  logic                                bready,
   input  logic [img_pkg::axi_addr_width-1:0]  araddr,
   input  logic                                arvalid,
   output logic                                arready,
   output logic [img_pkg::axi_data_width-1:0]  rdata,
   output logic [1:0]                          rresp,
   output logic                                rvalid,
   input  logic                                rready,
   output logic                                enable,
   output img_pkg::phase_t                     phase,
   input  logic                                frame_done
);

   logic        wr_go;
   logic        rd_go;
   logic [2:0]  ctrl_q;      // {phase, enable}
   logic [15:0] frame_cnt;

   // A pending response on either channel holds off new requests
   assign wr_go   = awvalid && wvalid && !bvalid && !rvalid;
   assign rd_go   = arvalid && !bvalid && !rvalid;
   assign awready = wr_go;
   assign wready  = wr_go;
   assign arready = rd_go;

   assign enable = ctrl_q[0];
   assign phase  = ctrl_q[2:1];

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         bvalid    <= 1'b0;
         rvalid    <= 1'b0;
         ctrl_q    <= '0;
         frame_cnt <= '0;
      end else begin
         if (wr_go) begin
            bvalid <= 1'b1;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
         if (rd_go) begin
            rvalid <= 1'b1;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
         if (wr_go && (awaddr == img_pkg::csr_ctrl_addr) && wstrb[0]) begin
            ctrl_q <= wdata[2:0];
         end
         frame_cnt <= frame_cnt + frame_done;   // Wraps at 16 bits
      end
   end

   always_ff @(posedge clk) begin
      if (wr_go) begin
         // Status writes are dropped but still answered okay
         if ((awaddr == img_pkg::csr_ctrl_addr) || (awaddr == img_pkg::csr_status_addr)) begin
            bresp <= img_pkg::axi_resp_okay;
         end else begin
            bresp <= img_pkg::axi_resp_slverr;
         end
      end
      if (rd_go) begin
         rdata <= '0;
         rresp <= img_pkg::axi_resp_okay;
         case (araddr)
            img_pkg::csr_ctrl_addr:   rdata[2:0]  <= ctrl_q;
            img_pkg::csr_status_addr: rdata[15:0] <= frame_cnt;
            default:                  rresp       <= img_pkg::axi_resp_slverr;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: rtl/demosaic_top.sv
`timescale 1ns/1ps
`default_nettype none

module demosaic_top (
   input  logic                                 clk,
   input  logic                                 resetb,
   input  logic                                 dvi,
   input  logic [3:0]                           dtypei,
   input  logic [15:0]                          datai,
   input  logic [img_pkg::axi_addr_width-1:0]   awaddr,
   input  logic                                 awvalid,
   output logic                                 awready,
   input  logic [img_pkg::axi_data_width-1:0]   wdata,
   input  logic [img_pkg::axi_data_width/8-1:0] wstrb,
   input  logic                                 wvalid,
   output logic                                 wready,
   output logic [1:0]                           bresp,
   output logic                                 bvalid,
   input  logic                                 bready,
   input  logic [img_pkg::axi_addr_width-1:0]   araddr,
   input  logic                                 arvalid,
   output logic                                 arready,
   output logic [img_pkg::axi_data_width-1:0]   rdata,
   output logic [1:0]                           rresp,
   output logic                                 rvalid,
   input  logic                                 rready,
   output logic                                 dvo,
   output logic [img_pkg::pixel_width-1:0]      r,
   output logic [img_pkg::pixel_width-1:0]      g,
   output logic [img_pkg::pixel_width-1:0]      b,
   output logic [3:0]                           dtypeo,
   output logic [15:0]                          meta_datao
);

   logic                  enable;
   img_pkg::phase_t       phase;
   logic                  frame_done;
   img_pkg::stream_word_u data_word;
   img_pkg::stream_word_u meta_word;

   kernel_if kif ();

   // Plain 16-bit words at the boundary, decoded inside
   assign data_word.meta = datai;
   assign meta_datao     = meta_word.meta;

   demosaic_csr csr_inst (
      .clk        (clk),
      .resetb     (resetb),
      .awaddr     (awaddr),
      .awvalid    (awvalid),
      .awready    (awready),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .wvalid     (wvalid),
      .wready     (wready),
      .bresp      (bresp),
      .bvalid     (bvalid),
      .bready     (bready),
      .araddr     (araddr),
      .arvalid    (arvalid),
      .arready    (arready),
      .rdata      (rdata),
      .rresp      (rresp),
      .rvalid     (rvalid),
      .rready     (rready),
      .enable     (enable),
      .phase      (phase),
      .frame_done (frame_done)
   );

   kernel kernel_inst (
      .clk    (clk),
      .resetb (resetb),
      .enable (enable),
      .dvi    (dvi),
      .dtypei (dtypei),
      .datai  (data_word),
      .kif    (kif.src)
   );

   interp_bilinear interp_inst (
      .clk        (clk),
      .resetb     (resetb),
      .phase      (phase),
      .kif        (kif.snk),
      .dvo        (dvo),
      .r          (r),
      .g          (g),
      .b          (b),
      .dtypeo     (dtypeo),
      .meta_datao (meta_word),
      .frame_done (frame_done)
   );

endmodule

`default_nettype wire

// File: sim/demosaic_tb.sv
`timescale 1ns/1ps
`default_nettype none

module demosaic_tb;

   localparam int num_cases = 10;
   localparam int max_beats = 256;

   typedef struct packed {
      logic                            en;
      img_pkg::phase_t                 ph;
      logic [7:0]                      rows;
      logic [7:0]                      cols;
      logic                            rnd;      // Random pixels, else flat value
      logic [img_pkg::pixel_width-1:0] flat;
      logic [15:0]                     fs_meta;
      logic [15:0]                     fe_meta;
   } case_t;

   localparam case_t case_table [0:num_cases-1] = '{
      '{1'b1, 2'd0, 8'd4, 8'd5, 1'b0, 10'h155, 16'ha001, 16'ha002},
      '{1'b1, 2'd1, 8'd5, 8'd4, 1'b0, 10'h3ff, 16'hb001, 16'hb002},
      '{1'b1, 2'd2, 8'd4, 8'd4, 1'b0, 10'h000, 16'hc001, 16'hc002},
      '{1'b1, 2'd3, 8'd5, 8'd6, 1'b0, 10'h2a7, 16'hd001, 16'hd002},
      '{1'b1, 2'd0, 8'd6, 8'd8, 1'b1, 10'h000, 16'h1111, 16'h2222},
      '{1'b1, 2'd1, 8'd6, 8'd8, 1'b1, 10'h000, 16'h3333, 16'h4444},
      '{1'b1, 2'd2, 8'd6, 8'd8, 1'b1, 10'h000, 16'h5555, 16'h6666},
      '{1'b1, 2'd3, 8'd6, 8'd8, 1'b1, 10'h000, 16'h7777, 16'h8888},
      '{1'b0, 2'd0, 8'd6, 8'd8, 1'b1, 10'h000, 16'h9999, 16'haaaa},   // Disabled frame
      '{1'b1, 2'd2, 8'd3, 8'd3, 1'b1, 10'h000, 16'hbeef, 16'hcafe}    // One output pixel
   };

   logic                                 clk;
   logic                                 resetb;
   logic                                 dvi;
   logic [3:0]                           dtypei;
   logic [15:0]                          datai;
   logic [img_pkg::axi_addr_width-1:0]   awaddr;
   logic                                 awvalid;
   logic                                 awready;
   logic [img_pkg::axi_data_width-1:0]   wdata;
   logic [img_pkg::axi_data_width/8-1:0] wstrb;
   logic                                 wvalid;
   logic                                 wready;
   logic [1:0]                           bresp;
   logic                                 bvalid;
   logic                                 bready;
   logic [img_pkg::axi_addr_width-1:0]   araddr;
   logic                                 arvalid;
   logic                                 arready;
   logic [img_pkg::axi_data_width-1:0]   rdata;
   logic [1:0]                           rresp;
   logic                                 rvalid;
   logic                                 rready;
   logic                                 dvo;
   logic [img_pkg::pixel_width-1:0]      r;
   logic [img_pkg::pixel_width-1:0]      g;
   logic [img_pkg::pixel_width-1:0]      b;
   logic [3:0]                           dtypeo;
   logic [15:0]                          meta_datao;

   int     errors = 0;
   int     checks = 0;
   integer seed   = 85386;

   // Image of the current case and its beats with expected responses
   logic [img_pkg::pixel_width-1:0] img [0:15][0:15];
   img_pkg::dtype_t                 bt_type [0:max_beats-1];
   img_pkg::stream_word_u           bt_data [0:max_beats-1];
   logic                            exp_dv  [0:max_beats-1];
   logic [3*img_pkg::pixel_width-1:0] exp_rgb [0:max_beats-1];

   demosaic_top demosaic_top_inst (
      .clk(clk), .resetb(resetb), .dvi(dvi), .dtypei(dtypei), .datai(datai),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
      .dvo(dvo), .r(r), .g(g), .b(b), .dtypeo(dtypeo), .meta_datao(meta_datao)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic report_mismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
      errors++;
      $display("MISMATCH at %0t: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
   endtask

   task automatic check_dv(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) report_mismatch({what, " dvo"}, got, exp);
   endtask

   task automatic check_rgb(input logic [3*img_pkg::pixel_width-1:0] got,
                            input logic [3*img_pkg::pixel_width-1:0] exp, input string what);
      checks++;
      if (got !== exp) report_mismatch({what, " rgb"}, got, exp);   // Packed r, g, b
   endtask

   task automatic check_dtype(input img_pkg::dtype_t got, input img_pkg::dtype_t exp,
                              input string what);
      checks++;
      if (got !== exp) report_mismatch({what, " dtype"}, got, exp);
   endtask

   task automatic check_meta(input img_pkg::stream_word_u got,
                             input img_pkg::stream_word_u exp, input string what);
      checks++;
      if (got !== exp) report_mismatch({what, " meta"}, got, exp);
   endtask

   task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
      checks++;
      if (got !== exp) report_mismatch({what, " resp"}, got, exp);
   endtask

   task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      if (got !== exp) report_mismatch({what, " data"}, got, exp);
   endtask

   // Bilinear reconstruction of one window, rounded averages
   function automatic logic [3*img_pkg::pixel_width-1:0] expected_rgb(
         input img_pkg::window_t w, input logic rp, input logic cp);
      int c;
      int plus;
      int diam;
      int vert;
      int horz;
      c    = w[1][1];
      plus = (int'(w[0][1]) + w[2][1] + w[1][0] + w[1][2] + 2) / 4;
      diam = (int'(w[0][0]) + w[0][2] + w[2][0] + w[2][2] + 2) / 4;
      vert = (int'(w[0][1]) + w[2][1] + 1) / 2;
      horz = (int'(w[1][0]) + w[1][2] + 1) / 2;
      case ({rp, cp})
         2'd0:    return {c[9:0], plus[9:0], diam[9:0]};
         2'd1:    return {horz[9:0], c[9:0], vert[9:0]};
         2'd2:    return {vert[9:0], c[9:0], horz[9:0]};
         default: return {diam[9:0], plus[9:0], c[9:0]};
      endcase
   endfunction

   task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
      int   wait_cnt;
      logic taken;
      wait_cnt = 0;
      taken    = 1'b0;
      resp     = 2'bxx;
      @(negedge clk);
      awaddr  = addr;
      wdata   = data;
      wstrb   = strb;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      bready  = 1'b1;
      while (!taken && wait_cnt < 20) begin
         @(posedge clk);
         taken = awready && wready;   // Handshake as the edge samples it
         wait_cnt++;
      end
      @(negedge clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      if (!taken) begin
         errors++;
         $display("AXI write to 0x%0h was never accepted", addr);
      end else if (bvalid) begin
         resp = bresp;
      end else begin
         errors++;
         $display("AXI write to 0x%0h got no response", addr);
      end
   endtask

   task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
      int   wait_cnt;
      logic taken;
      wait_cnt = 0;
      taken    = 1'b0;
      data     = 'x;
      resp     = 2'bxx;
      @(negedge clk);
      araddr  = addr;
      arvalid = 1'b1;
      rready  = 1'b1;
      while (!taken && wait_cnt < 20) begin
         @(posedge clk);
         taken = arready;
         wait_cnt++;
      end
      @(negedge clk);
      arvalid = 1'b0;
      if (!taken) begin
         errors++;
         $display("AXI read of 0x%0h was never accepted", addr);
      end else if (rvalid) begin
         data = rdata;
         resp = rresp;
      end else begin
         errors++;
         $display("AXI read of 0x%0h got no response", addr);
      end
   endtask

   task automatic add_beat(inout int nb, input img_pkg::dtype_t t, input logic [15:0] d,
                           input logic emit);
      bt_type[nb]      = t;
      bt_data[nb].meta = d;
      exp_dv[nb]       = emit;
      exp_rgb[nb]      = '0;
      nb++;
   endtask

   task automatic run_case(input int idx);
      case_t            cs;
      int               nb;
      int               npix;
      int               err0;
      logic [31:0]      rnd;
      logic [1:0]       resp;
      img_pkg::window_t w;
      string            what;
      cs   = case_table[idx];
      err0 = errors;
      nb   = 0;
      npix = 0;
      axi_write(img_pkg::csr_ctrl_addr, {29'd0, cs.ph, cs.en}, 4'hf, resp);
      check_resp(resp, img_pkg::axi_resp_okay, "ctrl write");
      for (int y = 0; y < cs.rows; y++) begin
         for (int x = 0; x < cs.cols; x++) begin
            rnd       = $random(seed);
            img[y][x] = cs.rnd ? rnd[9:0] : cs.flat;
         end
      end
      add_beat(nb, img_pkg::dtype_frame_start, cs.fs_meta, cs.en);
      for (int y = 0; y < cs.rows; y++) begin
         add_beat(nb, img_pkg::dtype_row_start, y[15:0], cs.en && y >= 2);
         for (int x = 0; x < cs.cols; x++) begin
            add_beat(nb, img_pkg::dtype_pixel, {6'd0, img[y][x]}, cs.en && y >= 2 && x >= 2);
            if (exp_dv[nb-1]) begin
               for (int wy = 0; wy < 3; wy++) begin
                  for (int wx = 0; wx < 3; wx++) begin
                     w[wy][wx] = img[y-2+wy][x-2+wx];   // Centred on y-1, x-1
                  end
               end
               exp_rgb[nb-1] = expected_rgb(w, cs.ph[1] ^ y[0], cs.ph[0] ^ x[0]);
            end
         end
         add_beat(nb, img_pkg::dtype_row_end, y[15:0], cs.en && y >= 2);
      end
      add_beat(nb, img_pkg::dtype_frame_end, cs.fe_meta, cs.en);
      // Each beat comes out two cycles after it is driven
      for (int k = 0; k < nb + 2; k++) begin
         @(negedge clk);
         if (k >= 2) begin
            what = $sformatf("case %0d beat %0d", idx, k - 2);
            check_dv(dvo, exp_dv[k-2], what);
            if (dvo && dtypeo == img_pkg::dtype_pixel) npix++;
            if (exp_dv[k-2]) begin
               check_dtype(dtypeo, bt_type[k-2], what);
               check_meta(meta_datao, bt_data[k-2], what);
               if (bt_type[k-2] == img_pkg::dtype_pixel) check_rgb({r, g, b}, exp_rgb[k-2], what);
            end
         end
         dvi    = (k < nb);
         dtypei = (k < nb) ? bt_type[k] : '0;
         datai  = (k < nb) ? bt_data[k] : '0;
      end
      if (npix != (cs.en ? (cs.rows - 2) * (cs.cols - 2) : 0)) begin
         report_mismatch($sformatf("case %0d pixel count", idx), npix,
                         cs.en ? (cs.rows - 2) * (cs.cols - 2) : 0);
      end
      $display("case %0d: en %0d phase %0d %0dx%0d, %0d pixels out, %0d errors",
               idx, cs.en, cs.ph, cs.rows, cs.cols, npix, errors - err0);
   endtask

   // Frame beats plus some slack per case for the register writes
   initial begin
      int limit;
      limit = 200;
      for (int i = 0; i < num_cases; i++) begin
         limit += 14 + case_table[i].rows * (case_table[i].cols + 2);
      end
      repeat (limit) @(posedge clk);
      $display("Timeout: run did not finish within %0d cycles", limit);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      logic [31:0] data;
      logic [1:0]  resp;
      int          enabled;
      int          err0;
      {dvi, dtypei, datai, awaddr, awvalid, wdata, wstrb, wvalid} = '0;
      {bready, araddr, arvalid, rready} = '0;
      enabled = 0;
      resetb  = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      resetb = 1'b1;
      err0   = errors;
      axi_write(img_pkg::csr_ctrl_addr, 32'h7, 4'hf, resp);
      check_resp(resp, img_pkg::axi_resp_okay, "ctrl write");
      axi_write(img_pkg::csr_ctrl_addr, 32'h0, 4'he, resp);   // Byte 0 not strobed
      axi_read(img_pkg::csr_ctrl_addr, data, resp);
      check_data(data, 32'h7, "ctrl readback");
      axi_write(4'h8, 32'h1, 4'hf, resp);
      check_resp(resp, img_pkg::axi_resp_slverr, "unmapped write");
      axi_read(4'h8, data, resp);
      check_resp(resp, img_pkg::axi_resp_slverr, "unmapped read");
      check_data(data, 32'h0, "unmapped read");
      $display("register access: %0d errors", errors - err0);
      for (int i = 0; i < num_cases; i++) begin
         run_case(i);
         enabled += case_table[i].en;
      end
      // Count is nonzero here, so a write that stores or clears would show
      axi_write(img_pkg::csr_status_addr, 32'h0, 4'hf, resp);
      check_resp(resp, img_pkg::axi_resp_okay, "status write");
      axi_read(img_pkg::csr_status_addr, data, resp);
      check_resp(resp, img_pkg::axi_resp_okay, "status read");
      check_data(data, enabled, "frame count");
      $display("%0d cases, %0d checks, %0d errors", num_cases + 1, checks, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: bayer_demosaic.f
rtl/img_pkg.sv
rtl/kernel_if.sv
rtl/line_buffer.sv
rtl/kernel.sv
rtl/interp_bilinear.sv
rtl/demosaic_csr.sv
rtl/demosaic_top.sv
sim/demosaic_tb.sv

// File: Bender.yml
package:
  name: bayer_demosaic

sources:
  - rtl/img_pkg.sv
  - rtl/kernel_if.sv
  - rtl/line_buffer.sv
  - rtl/kernel.sv
  - rtl/interp_bilinear.sv
  - rtl/demosaic_csr.sv
  - rtl/demosaic_top.sv
  - target: simulation
    files:
      - sim/demosaic_tb.sv
